// File: run.sh
#!/bin/sh
# build with verilator, run, then judge the log
rm -f sim.log
verilator --binary --timing -j 0 --top-module csr_tb -f src.f -o csr_sim \
  && ./obj_dir/csr_sim > sim.log 2>&1 \
  || echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -qx "TEST OK" sim.log 2>/dev/null && echo "result: pass" \
  || { echo "result: fail"; exit 1; }

// File: src.f
+incdir+verification
verilog/csr_pkg.sv
verilog/csr_access_ctrl.sv
verilog/csr_trap_regs.sv
verilog/csr_irq_regs.sv
verilog/csr_perf_counters.sv
verilog/csr_top.sv
verification/csr_tb.sv

// File: verification/csr_model.svh
//////////////////////////////
// reference model of the CSR state, included inside the testbench module
// advanced once per rising edge from the stimulus of that cycle
//////////////////////////////

`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

logic [1:0]  exp_priv;
logic        exp_mie, exp_mpie, exp_tw;
logic [1:0]  exp_mpp;
logic [31:0] exp_mscratch, exp_mepc, exp_mcause, exp_mtval, exp_mtvec, exp_mie_word;
logic [63:0] exp_mcycle, exp_minstret;
logic        exp_cyc_inh, exp_ret_inh;

function automatic logic csr_exists(logic [11:0] addr);
  case (addr)
    12'h300, 12'h301, 12'h304, 12'h305, 12'h320, 12'h340, 12'h341, 12'h342,
    12'h343, 12'h344, 12'hB00, 12'hB02, 12'hB80, 12'hB82, 12'hF14: return 1'b1;
    default: return 1'b0;
  endcase
endfunction

// missing address, privilege too low, or a write to read-only space
function automatic logic expect_illegal(logic [11:0] addr, logic [1:0] op);
  return !csr_exists(addr) || (addr[9:8] > exp_priv) || (addr[11:10] == 2'b11 && op != 2'b00);
endfunction

function automatic logic [31:0] expected_rdata(logic [11:0] addr);
  case (addr)
    12'h300: return {10'b0, exp_tw, 8'b0, exp_mpp, 3'b0, exp_mpie, 3'b0, exp_mie, 3'b0};
    12'h301: return 32'h4010_1104;   // MXL=1 with C, I, M and U
    12'h304: return exp_mie_word;
    12'h305: return exp_mtvec;
    12'h320: return {29'b0, exp_ret_inh, 1'b0, exp_cyc_inh};
    12'h340: return exp_mscratch;
    12'h341: return exp_mepc;
    12'h342: return exp_mcause;
    12'h343: return exp_mtval;
    12'h344: return mip_word;
    12'hB00: return exp_mcycle[31:0];
    12'hB80: return exp_mcycle[63:32];
    12'hB02: return exp_minstret[31:0];
    12'hB82: return exp_minstret[63:32];
    12'hF14: return hart_id_i;
    default: return 32'b0;
  endcase
endfunction

function automatic logic [17:0] expected_irqs();
  logic [31:0] q;
  q = mip_word & exp_mie_word;
  return {q[3], q[7], q[11], q[30:16]};
endfunction

task automatic reset_state();
  exp_priv     = 2'b11;
  exp_mie      = 1'b0;
  exp_mpie     = 1'b1;
  exp_mpp      = 2'b00;
  exp_tw       = 1'b0;
  exp_mscratch = '0;
  exp_mepc     = '0;
  exp_mcause   = '0;
  exp_mtval    = '0;
  exp_mtvec    = 32'h1;
  exp_mie_word = '0;
  exp_mcycle   = '0;
  exp_minstret = '0;
  exp_cyc_inh  = 1'b0;
  exp_ret_inh  = 1'b0;
endtask

task automatic apply_write(logic [11:0] addr, logic [31:0] w);
  case (addr)
    12'h300: begin
      exp_mie  = w[3];
      exp_mpie = w[7];
      exp_tw   = w[21];
      exp_mpp  = (w[12:11] == 2'b00) ? 2'b00 : 2'b11;  // only U and M exist
    end
    12'h304: exp_mie_word = w & 32'h7FFF_0888;         // msie, mtie, meie, fast 30:16
    12'h305: exp_mtvec    = {w[31:8], 8'h01};
    12'h320: begin
      exp_cyc_inh = w[0];
      exp_ret_inh = w[2];
    end
    12'h340: exp_mscratch = w;
    12'h341: exp_mepc     = {w[31:1], 1'b0};
    12'h342: exp_mcause   = w & 32'h8000_001F;
    12'h343: exp_mtval    = w;
    12'hB00: exp_mcycle[31:0]    = w;
    12'hB80: exp_mcycle[63:32]   = w;
    12'hB02: exp_minstret[31:0]  = w;
    12'hB82: exp_minstret[63:32] = w;
    default: ;
  endcase
endtask

// one rising edge with the inputs held during the cycle before it
task automatic advance_state();
  logic [31:0] old;
  logic [31:0] w;
  logic        we;
  logic        cyc_we;
  logic        ret_we;
  logic [1:0]  old_priv;
  logic [1:0]  old_mpp;
  logic        old_mie;
  logic        old_mpie;
  old_priv = exp_priv;
  old_mpp  = exp_mpp;
  old_mie  = exp_mie;
  old_mpie = exp_mpie;
  old      = expected_rdata(csr_addr_i);
  case (csr_op_i)
    CSR_OP_SET:   w = csr_wdata_i | old;
    CSR_OP_CLEAR: w = old & ~csr_wdata_i;
    default:      w = csr_wdata_i;
  endcase
  we = csr_access_i && csr_op_en_i && csr_op_i != CSR_OP_READ &&
       !expect_illegal(csr_addr_i, csr_op_i);
  cyc_we = we && (csr_addr_i == CSR_MCYCLE || csr_addr_i == CSR_MCYCLEH);
  ret_we = we && (csr_addr_i == CSR_MINSTRET || csr_addr_i == CSR_MINSTRETH);
  if (csr_mtvec_init_i) exp_mtvec = {boot_addr_i[31:8], 8'h01};
  if (!cyc_we && !exp_cyc_inh) exp_mcycle = exp_mcycle + 64'd1;
  if (!ret_we && !exp_ret_inh && instr_ret_i) exp_minstret = exp_minstret + 64'd1;
  if (we) apply_write(csr_addr_i, w);
  if (trap_req_i.save_cause) begin   // trap wins over the software write
    exp_priv   = 2'b11;
    exp_mie    = 1'b0;
    exp_mpie   = old_mie;
    exp_mpp    = old_priv;
    exp_mepc   = trap_req_i.exc_pc;
    exp_mcause = {trap_req_i.cause[5], 26'b0, trap_req_i.cause[4:0]};
    exp_mtval  = trap_req_i.tval;
  end else if (trap_req_i.restore_mret) begin
    exp_priv = old_mpp;
    exp_mie  = old_mpie;
    exp_mpie = 1'b1;
    exp_mpp  = 2'b00;
  end
endtask

`endif

// File: verification/csr_tb.sv
//////////////////////////////
// testbench of the machine-mode CSR file
// random accesses, traps, interrupts and counters against a model
//////////////////////////////

`timescale 1ns/100ps

module csr_tb import csr_pkg::*; ();

  localparam int CLK_PERIOD = 40;
  localparam int N_RANDOM   = 300;
  localparam int N_LEGAL    = 60;
  localparam int N_TRAP     = 20;
  localparam int N_IRQ      = 50;
  localparam int N_CNT      = 4;
  localparam int N_RUN      = 40;
  // cycles per test, summed for the watchdog
  localparam int TOTAL_CYCLES = 10 + 20 + (N_RANDOM + 10) + (N_LEGAL + 15) + N_TRAP * 16
                              + 10 + N_IRQ * 3 + N_CNT * (N_RUN + 12) + 20;

  logic        clk_i;
  logic        rst_ni;
  xlen_t       hart_id_i;
  logic        csr_access_i;
  csr_addr_e   csr_addr_i;
  csr_op_e     csr_op_i;
  logic        csr_op_en_i;
  xlen_t       csr_wdata_i;
  xlen_t       csr_rdata_o;
  logic        illegal_csr_insn_o;
  trap_req_t   trap_req_i;
  logic        csr_mtvec_init_i;
  xlen_t       boot_addr_i;
  priv_lvl_e   priv_mode_o;
  logic        csr_mstatus_mie_o;
  logic        csr_mstatus_tw_o;
  xlen_t       csr_mepc_o;
  xlen_t       csr_mtvec_o;
  logic        irq_software_i;
  logic        irq_timer_i;
  logic        irq_external_i;
  logic [14:0] irq_fast_i;
  irqs_t       irqs_o;
  logic        irq_pending_o;
  logic        instr_ret_i;
  logic [31:0] mip_word;   // live irq inputs at their mip positions
  integer      seed = 32'h9661f857;

  assign mip_word = {1'b0, irq_fast_i, 4'b0, irq_external_i, 3'b0, irq_timer_i, 3'b0,
                     irq_software_i, 3'b0};

  `include "csr_model.svh"

  csr_top i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #(TOTAL_CYCLES * 2 * CLK_PERIOD);
    $display("timeout: the tests did not finish within %0d clock periods", TOTAL_CYCLES * 2);
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  function automatic logic [11:0] pick_reg(logic [2:0] sel);
    case (sel)
      3'd1:    return CSR_MEPC;
      3'd2:    return CSR_MCAUSE;
      3'd3:    return CSR_MTVAL;
      3'd4:    return CSR_MTVEC;
      3'd5:    return CSR_MIE;
      3'd6:    return CSR_MSTATUS;
      default: return CSR_MSCRATCH;
    endcase
  endfunction

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  // wait for the edge, let the model take it, drive just after
  task automatic step();
    @(posedge clk_i);
    advance_state();
    #2;
  endtask

  task automatic access(input string name, input logic [11:0] addr, input logic [1:0] op,
                        input logic [31:0] wdata, output logic [31:0] rdata);
    logic ill;
    csr_access_i = 1'b1;
    csr_op_en_i  = 1'b1;
    csr_addr_i   = csr_addr_e'(addr);
    csr_op_i     = csr_op_e'(op);
    csr_wdata_i  = wdata;
    #10;
    ill = expect_illegal(addr, op);
    check({name, " illegal"}, 64'(ill), 64'(illegal_csr_insn_o));
    if (!ill) check({name, " rdata"}, 64'(expected_rdata(addr)), 64'(csr_rdata_o));
    rdata = csr_rdata_o;
    step();
    csr_access_i = 1'b0;
    csr_op_en_i  = 1'b0;
  endtask

  task automatic read_all(input string name);
    logic [31:0] rd;
    for (int s = 0; s < 7; s++) access(name, pick_reg(3'(s)), CSR_OP_READ, '0, rd);
  endtask

  task automatic check_outputs(input string name);
    logic [17:0] irqs;
    irqs = expected_irqs();
    check({name, " priv"}, 64'(exp_priv), 64'(priv_mode_o));
    check({name, " mstatus_mie"}, 64'(exp_mie), 64'(csr_mstatus_mie_o));
    check({name, " mstatus_tw"}, 64'(exp_tw), 64'(csr_mstatus_tw_o));
    check({name, " mepc"}, 64'(exp_mepc), 64'(csr_mepc_o));
    check({name, " mtvec"}, 64'(exp_mtvec), 64'(csr_mtvec_o));
    check({name, " irqs"}, 64'(irqs), 64'(irqs_o));
    check({name, " pending"}, 64'(|irqs), 64'(irq_pending_o));
  endtask

  task automatic trap_save();
    logic [31:0] r;
    r                     = rand32();
    trap_req_i            = '0;
    trap_req_i.save_cause = 1'b1;
    trap_req_i.exc_pc     = rand32() & ~32'h1;   // pc is halfword aligned
    trap_req_i.cause      = r[5:0];
    trap_req_i.tval       = rand32();
    step();
    trap_req_i = '0;
  endtask

  task automatic trap_mret();
    trap_req_i              = '0;
    trap_req_i.restore_mret = 1'b1;
    step();
    trap_req_i = '0;
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] rd;
    logic [31:0] rd_lo;
    logic [31:0] rd_hi;
    logic [11:0] addr;
    logic [63:0] wr_cyc;
    logic        inh;
    rst_ni           = 1'b0;
    hart_id_i        = rand32();
    boot_addr_i      = rand32();
    csr_access_i     = 1'b0;
    csr_addr_i       = CSR_MSTATUS;
    csr_op_i         = CSR_OP_READ;
    csr_op_en_i      = 1'b0;
    csr_wdata_i      = '0;
    trap_req_i       = '0;
    csr_mtvec_init_i = 1'b0;
    irq_software_i   = 1'b0;
    irq_timer_i      = 1'b0;
    irq_external_i   = 1'b0;
    irq_fast_i       = '0;
    instr_ret_i      = 1'b0;
    repeat (10) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    reset_state();

    //////////////////////////////
    // reset values and constants
    check_outputs("reset");
    access("reset mstatus", CSR_MSTATUS, CSR_OP_READ, '0, rd);
    check("reset mstatus", 64'h80, 64'(rd));   // MPIE=1, MPP=U
    access("reset mtvec", CSR_MTVEC, CSR_OP_READ, '0, rd);
    check("reset mtvec", 64'h1, 64'(rd));
    access("reset misa", CSR_MISA, CSR_OP_READ, '0, rd);
    access("reset mhartid", CSR_MHARTID, CSR_OP_READ, '0, rd);
    access("reset mepc", CSR_MEPC, CSR_OP_READ, '0, rd);
    csr_mtvec_init_i = 1'b1;
    step();
    csr_mtvec_init_i = 1'b0;
    access("boot mtvec", CSR_MTVEC, CSR_OP_READ, '0, rd);
    check_outputs("boot");

    //////////////////////////////
    // random access to the trap and irq registers
    for (int i = 0; i < N_RANDOM; i++) begin
      r = rand32();
      access("random", pick_reg(r[2:0]), r[4:3], rand32(), rd);
    end
    read_all("random");

    // missing addresses and read-only mhartid
    for (int i = 0; i < N_LEGAL; i++) begin
      do begin
        r    = rand32();
        addr = r[11:0];
      end while (csr_exists(addr));
      access("legality", addr, r[13:12], rand32(), rd);
    end
    access("legality mhartid", CSR_MHARTID, CSR_OP_WRITE, rand32(), rd);
    access("legality mhartid", CSR_MHARTID, CSR_OP_SET, rand32(), rd);
    access("legality mhartid", CSR_MHARTID, CSR_OP_CLEAR, rand32(), rd);
    access("legality mhartid read", CSR_MHARTID, CSR_OP_READ, '0, rd);
    read_all("legality");

    //////////////////////////////
    // trap entry, mret to user mode, locked out until the next trap
    for (int i = 0; i < N_TRAP; i++) begin
      trap_save();
      check_outputs("trap save");
      access("trap mepc", CSR_MEPC, CSR_OP_READ, '0, rd);
      access("trap mcause", CSR_MCAUSE, CSR_OP_READ, '0, rd);
      access("trap mtval", CSR_MTVAL, CSR_OP_READ, '0, rd);
      access("trap mstatus", CSR_MSTATUS, CSR_OP_READ, '0, rd);
      access("trap mstatus", CSR_MSTATUS, CSR_OP_WRITE, rand32(), rd);
      access("trap mpp", CSR_MSTATUS, CSR_OP_CLEAR, 32'h0000_1800, rd);
      trap_mret();
      check_outputs("trap mret");
      for (int k = 0; k < 4; k++) begin
        r = rand32();
        access("trap user", pick_reg(r[2:0]), r[4:3], rand32(), rd);
      end
    end
    trap_save();
    check_outputs("trap final");
    read_all("trap");

    // qualified interrupts follow the inputs in the same cycle
    for (int i = 0; i < N_IRQ; i++) begin
      access("irq mie", CSR_MIE, CSR_OP_WRITE, rand32(), rd);
      r              = rand32();
      irq_software_i = r[0];
      irq_timer_i    = r[1];
      irq_external_i = r[2];
      irq_fast_i     = r[17:3];
      #10;
      check_outputs("irq");
      step();
      access("irq mip", CSR_MIP, r[19:18], rand32(), rd);  // mip only mirrors the inputs
    end

    //////////////////////////////
    // counters with mcycle inhibited on odd rounds, minstret in the later two
    for (int i = 0; i < N_CNT; i++) begin
      inh    = i[0];
      wr_cyc = {rand32(), rand32()};
      r      = rand32();
      access("counter inhibit", CSR_MCOUNTINHIBIT, CSR_OP_WRITE, {r[31:3], i[1], r[1], inh}, rd);
      access("counter mcycle", CSR_MCYCLE, CSR_OP_WRITE, wr_cyc[31:0], rd);
      access("counter mcycleh", CSR_MCYCLEH, CSR_OP_WRITE, wr_cyc[63:32], rd);
      access("counter minstret", CSR_MINSTRET, CSR_OP_WRITE, rand32(), rd);
      access("counter minstreth", CSR_MINSTRETH, CSR_OP_WRITE, rand32(), rd);
      for (int c = 0; c < N_RUN; c++) begin
        r           = rand32();
        instr_ret_i = r[0];
        step();
      end
      instr_ret_i = 1'b0;
      access("counter mcycle", CSR_MCYCLE, CSR_OP_READ, '0, rd_lo);
      access("counter mcycleh", CSR_MCYCLEH, CSR_OP_READ, '0, rd_hi);
      if (inh) check("counter hold", wr_cyc, {rd_hi, rd_lo});
      access("counter minstret", CSR_MINSTRET, CSR_OP_READ, '0, rd);
      access("counter minstreth", CSR_MINSTRETH, CSR_OP_READ, '0, rd);
    end
    access("counter inhibit", CSR_MCOUNTINHIBIT, CSR_OP_READ, '0, rd);

    $display("TEST OK");
    $finish;
  end

endmodule

// File: verilog/csr_access_ctrl.sv
//////////////////////////////
// csr access decode: legality check, read mux, set/clear data and
// the per-register write strobes for the datapath modules
//////////////////////////////

`timescale 1ns/100ps

module csr_access_ctrl import csr_pkg::*; (
  input  logic       csr_access_i,
  input  csr_addr_e  csr_addr_i,
  input  csr_op_e    csr_op_i,
  input  logic       csr_op_en_i,
  input  xlen_t      csr_wdata_i,
  input  xlen_t      hart_id_i,
  input  trap_view_t trap_view_i,
  input  irq_view_t  irq_view_i,
  input  cnt_view_t  cnt_view_i,
  output xlen_t      csr_rdata_o,
  output logic       illegal_csr_insn_o,
  output csr_wr_t    csr_wr_o
);

  logic [11:0] csr_addr;
  logic        illegal_addr;
  logic        illegal_priv;
  logic        illegal_write;
  logic        csr_wreq;
  logic        csr_we;

  assign csr_addr = csr_addr_i;

  // place the interrupt fields at their mie/mip bit positions
  function automatic xlen_t irq_word(irqs_t irqs);
    xlen_t word;
    word                   = '0;
    word[MSIX_BIT]         = irqs.irq_software;
    word[MTIX_BIT]         = irqs.irq_timer;
    word[MEIX_BIT]         = irqs.irq_external;
    word[MFIX_HI:MFIX_LO]  = irqs.irq_fast;
    return word;
  endfunction

  ////////////////////////////////
  // read mux
  ////////////////////////////////
  always_comb begin
    csr_rdata_o  = '0;
    illegal_addr = 1'b0;
    case (csr_addr_i)
      CSR_MSTATUS: begin
        csr_rdata_o[MSTATUS_MIE_BIT]                = trap_view_i.mstatus_mie;
        csr_rdata_o[MSTATUS_MPIE_BIT]               = trap_view_i.mstatus_mpie;
        csr_rdata_o[MSTATUS_MPP_HI:MSTATUS_MPP_LO]  = trap_view_i.mstatus_mpp;
        csr_rdata_o[MSTATUS_TW_BIT]                 = trap_view_i.mstatus_tw;
      end
      CSR_MISA:          csr_rdata_o = MISA_VALUE;
      CSR_MIE:           csr_rdata_o = irq_word(irq_view_i.mie);
      CSR_MIP:           csr_rdata_o = irq_word(irq_view_i.mip);
      CSR_MTVEC:         csr_rdata_o = trap_view_i.mtvec;
      CSR_MSCRATCH:      csr_rdata_o = trap_view_i.mscratch;
      CSR_MEPC:          csr_rdata_o = trap_view_i.mepc;
      CSR_MCAUSE:        csr_rdata_o = {trap_view_i.mcause[5], 26'b0, trap_view_i.mcause[4:0]};
      CSR_MTVAL:         csr_rdata_o = trap_view_i.mtval;
      CSR_MCOUNTINHIBIT: begin
        csr_rdata_o[0] = cnt_view_i.mcycle_inhibit;
        csr_rdata_o[2] = cnt_view_i.minstret_inhibit;  // bit 1 and 31:3 read zero
      end
      CSR_MCYCLE:        csr_rdata_o = cnt_view_i.mcycle[31:0];
      CSR_MCYCLEH:       csr_rdata_o = cnt_view_i.mcycle[63:32];
      CSR_MINSTRET:      csr_rdata_o = cnt_view_i.minstret[31:0];
      CSR_MINSTRETH:     csr_rdata_o = cnt_view_i.minstret[63:32];
      CSR_MHARTID:       csr_rdata_o = hart_id_i;
      default:           illegal_addr = 1'b1;
    endcase
  end

  ////////////////////////////////
  // legality
  ////////////////////////////////
  assign csr_wreq      = (csr_op_i != CSR_OP_READ);
  assign illegal_priv  = (csr_addr[9:8] > trap_view_i.priv);
  assign illegal_write = (csr_addr[11:10] == 2'b11) && csr_wreq;  // read-only space

  assign illegal_csr_insn_o = csr_access_i & (illegal_addr | illegal_priv | illegal_write);

  assign csr_we = csr_op_en_i & csr_wreq & ~illegal_csr_insn_o;

  // write data and strobes
  always_comb begin
    csr_wr_o = '0;
    case (csr_op_i)
      CSR_OP_SET:   csr_wr_o.wdata = csr_wdata_i | csr_rdata_o;
      CSR_OP_CLEAR: csr_wr_o.wdata = ~csr_wdata_i & csr_rdata_o;
      default:      csr_wr_o.wdata = csr_wdata_i;
    endcase

    if (csr_we) begin
      case (csr_addr_i)
        CSR_MSTATUS:       csr_wr_o.mstatus_we       = 1'b1;
        CSR_MIE:           csr_wr_o.mie_we           = 1'b1;
        CSR_MSCRATCH:      csr_wr_o.mscratch_we      = 1'b1;
        CSR_MEPC:          csr_wr_o.mepc_we          = 1'b1;
        CSR_MCAUSE:        csr_wr_o.mcause_we        = 1'b1;
        CSR_MTVAL:         csr_wr_o.mtval_we         = 1'b1;
        CSR_MTVEC:         csr_wr_o.mtvec_we         = 1'b1;
        CSR_MCOUNTINHIBIT: csr_wr_o.mcountinhibit_we = 1'b1;
        CSR_MCYCLE:        csr_wr_o.mcycle_we        = 1'b1;
        CSR_MCYCLEH:       csr_wr_o.mcycleh_we       = 1'b1;
        CSR_MINSTRET:      csr_wr_o.minstret_we      = 1'b1;
        CSR_MINSTRETH:     csr_wr_o.minstreth_we     = 1'b1;
        default:           ;  // misa, mip, mhartid have no state to write
      endcase
    end
  end

endmodule

// File: verilog/csr_irq_regs.sv
//////////////////////////////
// mie register, live mip view and qualified interrupt requests
//////////////////////////////

`timescale 1ns/100ps

module csr_irq_regs import csr_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  csr_wr_t     csr_wr_i,
  input  logic        irq_software_i,
  input  logic        irq_timer_i,
  input  logic        irq_external_i,
  input  logic [14:0] irq_fast_i,
  output irq_view_t   irq_view_o,
  output irqs_t       irqs_o,
  output logic        irq_pending_o
);

  irqs_t mie_q;
  irqs_t mip;

  // no flops on mip, a sleeping core must wake without a clock
  assign mip = '{
    irq_software: irq_software_i,
    irq_timer:    irq_timer_i,
    irq_external: irq_external_i,
    irq_fast:     irq_fast_i
  };

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mie_q <= '0;
    end else if (csr_wr_i.mie_we) begin
      mie_q.irq_software <= csr_wr_i.wdata[MSIX_BIT];
      mie_q.irq_timer    <= csr_wr_i.wdata[MTIX_BIT];
      mie_q.irq_external <= csr_wr_i.wdata[MEIX_BIT];
      mie_q.irq_fast     <= csr_wr_i.wdata[MFIX_HI:MFIX_LO];
    end
  end

  assign irqs_o        = mip & mie_q;
  assign irq_pending_o = |irqs_o;
  assign irq_view_o    = '{mie: mie_q, mip: mip};

endmodule

// File: verilog/csr_perf_counters.sv
//////////////////////////////
// mcycle and minstret, 64 bits each, written in 32-bit halves,
// with the matching mcountinhibit bits
//////////////////////////////

`timescale 1ns/100ps

module csr_perf_counters import csr_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  csr_wr_t   csr_wr_i,
  input  logic      instr_ret_i,
  output cnt_view_t cnt_view_o
);

  counter_t mcycle_q, mcycle_d;
  counter_t minstret_q, minstret_d;
  logic     mcycle_inh_q;
  logic     minstret_inh_q;
  logic     mcycle_inc;
  logic     minstret_inc;

  // a write to either half wins over the increment
  function automatic counter_t cnt_next(counter_t cnt, logic inc, logic we_lo, logic we_hi,
                                        xlen_t wdata);
    counter_t nxt;
    if (we_lo) begin
      nxt = {cnt[63:32], wdata};
    end else if (we_hi) begin
      nxt = {wdata, cnt[31:0]};
    end else begin
      nxt = cnt + 64'(inc);
    end
    return nxt;
  endfunction

  assign mcycle_inc   = ~mcycle_inh_q;                  // every edge
  assign minstret_inc = instr_ret_i & ~minstret_inh_q;

  assign mcycle_d   = cnt_next(mcycle_q, mcycle_inc, csr_wr_i.mcycle_we,
                               csr_wr_i.mcycleh_we, csr_wr_i.wdata);
  assign minstret_d = cnt_next(minstret_q, minstret_inc, csr_wr_i.minstret_we,
                               csr_wr_i.minstreth_we, csr_wr_i.wdata);

  ////////////////////////////////
  // state
  ////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mcycle_q   <= '0;
      minstret_q <= '0;
    end else begin
      mcycle_q   <= mcycle_d;
      minstret_q <= minstret_d;
    end
  end

  // only bits 0 and 2 exist
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mcycle_inh_q   <= 1'b0;
      minstret_inh_q <= 1'b0;
    end else if (csr_wr_i.mcountinhibit_we) begin
      mcycle_inh_q   <= csr_wr_i.wdata[0];
      minstret_inh_q <= csr_wr_i.wdata[2];
    end
  end

  assign cnt_view_o = '{
    mcycle:           mcycle_q,
    minstret:         minstret_q,
    mcycle_inhibit:   mcycle_inh_q,
    minstret_inhibit: minstret_inh_q
  };

endmodule

// File: verilog/csr_pkg.sv
//////////////////////////////
// shared types, CSR addresses and constants of the machine-mode CSR file
// imported with a wildcard by every module of the block
//////////////////////////////

package csr_pkg;

  typedef logic [31:0] xlen_t;     // csr data word
  typedef logic [5:0]  cause_t;    // {interrupt flag, 5-bit code}
  typedef logic [63:0] counter_t;

  // implemented csr addresses
  typedef enum logic [11:0] {
    CSR_MSTATUS       = 12'h300,
    CSR_MISA          = 12'h301,
    CSR_MIE           = 12'h304,
    CSR_MTVEC         = 12'h305,
    CSR_MCOUNTINHIBIT = 12'h320,
    CSR_MSCRATCH      = 12'h340,
    CSR_MEPC          = 12'h341,
    CSR_MCAUSE        = 12'h342,
    CSR_MTVAL         = 12'h343,
    CSR_MIP           = 12'h344,
    CSR_MCYCLE        = 12'hB00,
    CSR_MINSTRET      = 12'hB02,
    CSR_MCYCLEH       = 12'hB80,
    CSR_MINSTRETH     = 12'hB82,
    CSR_MHARTID       = 12'hF14
  } csr_addr_e;

  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  typedef struct packed {
    logic        irq_software;
    logic        irq_timer;
    logic        irq_external;
    logic [14:0] irq_fast;
  } irqs_t;

  ////////////////////////////////
  // block-internal buses
  ////////////////////////////////

  // one strobe per writable register, plus the final write word
  typedef struct packed {
    logic  mstatus_we;
    logic  mie_we;
    logic  mscratch_we;
    logic  mepc_we;
    logic  mcause_we;
    logic  mtval_we;
    logic  mtvec_we;
    logic  mcountinhibit_we;
    logic  mcycle_we;
    logic  mcycleh_we;
    logic  minstret_we;
    logic  minstreth_we;
    xlen_t wdata;
  } csr_wr_t;

  // from the exception controller
  typedef struct packed {
    logic   save_cause;
    logic   restore_mret;
    xlen_t  exc_pc;
    cause_t cause;
    xlen_t  tval;
  } trap_req_t;

  typedef struct packed {
    priv_lvl_e priv;
    logic      mstatus_mie;
    logic      mstatus_mpie;
    priv_lvl_e mstatus_mpp;
    logic      mstatus_tw;
    xlen_t     mscratch;
    xlen_t     mepc;
    cause_t    mcause;
    xlen_t     mtval;
    xlen_t     mtvec;
  } trap_view_t;

  typedef struct packed {
    irqs_t mie;
    irqs_t mip;
  } irq_view_t;

  typedef struct packed {
    counter_t mcycle;
    counter_t minstret;
    logic     mcycle_inhibit;
    logic     minstret_inhibit;
  } cnt_view_t;

  // bit positions
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MSTATUS_MPP_LO   = 11;
  localparam int MSTATUS_MPP_HI   = 12;
  localparam int MSTATUS_TW_BIT   = 21;
  localparam int MSIX_BIT         = 3;
  localparam int MTIX_BIT         = 7;
  localparam int MEIX_BIT         = 11;
  localparam int MFIX_LO          = 16;
  localparam int MFIX_HI          = 30;

  // rv32 with C, I, M and user mode, MXL = 1
  localparam xlen_t MISA_VALUE = (32'd1 << 2) | (32'd1 << 8) | (32'd1 << 12)
                               | (32'd1 << 20) | (32'd1 << 30);

  localparam logic [1:0] MTVEC_MODE_VECTORED = 2'b01;
  localparam int         MTVEC_ALIGN_BITS    = 8;     // 256-byte aligned base
  localparam xlen_t      MSTATUS_RESET       = 32'h0000_0080; // MPIE=1, MPP=U

endpackage

// File: verilog/csr_top.sv
//////////////////////////////
// machine-mode CSR file top level
// access control plus trap, interrupt and counter datapaths
//////////////////////////////

`timescale 1ns/100ps

module csr_top import csr_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  xlen_t       hart_id_i,
  // csr access port
  input  logic        csr_access_i,
  input  csr_addr_e   csr_addr_i,
  input  csr_op_e     csr_op_i,
  input  logic        csr_op_en_i,
  input  xlen_t       csr_wdata_i,
  output xlen_t       csr_rdata_o,
  output logic        illegal_csr_insn_o,
  // trap control
  input  trap_req_t   trap_req_i,
  input  logic        csr_mtvec_init_i,
  input  xlen_t       boot_addr_i,
  output priv_lvl_e   priv_mode_o,
  output logic        csr_mstatus_mie_o,
  output logic        csr_mstatus_tw_o,
  output xlen_t       csr_mepc_o,
  output xlen_t       csr_mtvec_o,
  // interrupts
  input  logic        irq_software_i,
  input  logic        irq_timer_i,
  input  logic        irq_external_i,
  input  logic [14:0] irq_fast_i,
  output irqs_t       irqs_o,
  output logic        irq_pending_o,
  input  logic        instr_ret_i      // retired this cycle
);

  csr_wr_t    csr_wr;
  trap_view_t trap_view;
  irq_view_t  irq_view;
  cnt_view_t  cnt_view;

  csr_access_ctrl i_access_ctrl (
    .csr_access_i       (csr_access_i),
    .csr_addr_i         (csr_addr_i),
    .csr_op_i           (csr_op_i),
    .csr_op_en_i        (csr_op_en_i),
    .csr_wdata_i        (csr_wdata_i),
    .hart_id_i          (hart_id_i),
    .trap_view_i        (trap_view),
    .irq_view_i         (irq_view),
    .cnt_view_i         (cnt_view),
    .csr_rdata_o        (csr_rdata_o),
    .illegal_csr_insn_o (illegal_csr_insn_o),
    .csr_wr_o           (csr_wr)
  );

  csr_trap_regs i_trap_regs (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .csr_wr_i          (csr_wr),
    .trap_req_i        (trap_req_i),
    .csr_mtvec_init_i  (csr_mtvec_init_i),
    .boot_addr_i       (boot_addr_i),
    .trap_view_o       (trap_view),
    .priv_mode_o       (priv_mode_o),
    .csr_mstatus_mie_o (csr_mstatus_mie_o),
    .csr_mstatus_tw_o  (csr_mstatus_tw_o),
    .csr_mepc_o        (csr_mepc_o),
    .csr_mtvec_o       (csr_mtvec_o)
  );

  csr_irq_regs i_irq_regs (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .csr_wr_i       (csr_wr),
    .irq_software_i (irq_software_i),
    .irq_timer_i    (irq_timer_i),
    .irq_external_i (irq_external_i),
    .irq_fast_i     (irq_fast_i),
    .irq_view_o     (irq_view),
    .irqs_o         (irqs_o),
    .irq_pending_o  (irq_pending_o)
  );

  csr_perf_counters i_perf_counters (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .csr_wr_i    (csr_wr),
    .instr_ret_i (instr_ret_i),
    .cnt_view_o  (cnt_view)
  );

endmodule

// File: verilog/csr_trap_regs.sv
//////////////////////////////
// privilege, mstatus and trap registers: software writes with
// legalisation, trap save and MRET restore
//////////////////////////////

`timescale 1ns/100ps

module csr_trap_regs import csr_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  csr_wr_t    csr_wr_i,
  input  trap_req_t  trap_req_i,
  input  logic       csr_mtvec_init_i,
  input  xlen_t      boot_addr_i,
  output trap_view_t trap_view_o,
  output priv_lvl_e  priv_mode_o,
  output logic       csr_mstatus_mie_o,
  output logic       csr_mstatus_tw_o,
  output xlen_t      csr_mepc_o,
  output xlen_t      csr_mtvec_o
);

  trap_view_t regs_q, regs_d;

  // base keeps the aligned upper bits, mode is always vectored
  function automatic xlen_t mtvec_form(xlen_t base);
    return {base[31:MTVEC_ALIGN_BITS], {(MTVEC_ALIGN_BITS-2){1'b0}}, MTVEC_MODE_VECTORED};
  endfunction

  always_comb begin
    regs_d = regs_q;

    if (csr_mtvec_init_i) begin
      regs_d.mtvec = mtvec_form(boot_addr_i);
    end

    ////////////////////////////////
    // software writes
    ////////////////////////////////
    if (csr_wr_i.mstatus_we) begin
      regs_d.mstatus_mie  = csr_wr_i.wdata[MSTATUS_MIE_BIT];
      regs_d.mstatus_mpie = csr_wr_i.wdata[MSTATUS_MPIE_BIT];
      regs_d.mstatus_tw   = csr_wr_i.wdata[MSTATUS_TW_BIT];
      // anything other than U is taken as M
      regs_d.mstatus_mpp  = (csr_wr_i.wdata[MSTATUS_MPP_HI:MSTATUS_MPP_LO] == PRIV_LVL_U) ?
                            PRIV_LVL_U : PRIV_LVL_M;
    end
    if (csr_wr_i.mscratch_we) regs_d.mscratch = csr_wr_i.wdata;
    if (csr_wr_i.mepc_we)     regs_d.mepc     = {csr_wr_i.wdata[31:1], 1'b0};
    if (csr_wr_i.mcause_we)   regs_d.mcause   = {csr_wr_i.wdata[31], csr_wr_i.wdata[4:0]};
    if (csr_wr_i.mtval_we)    regs_d.mtval    = csr_wr_i.wdata;
    if (csr_wr_i.mtvec_we)    regs_d.mtvec    = mtvec_form(csr_wr_i.wdata);

    // exception controller wins over software writes
    if (trap_req_i.save_cause) begin
      regs_d.priv         = PRIV_LVL_M;
      regs_d.mstatus_mie  = 1'b0;               // interrupts off in handler
      regs_d.mstatus_mpie = regs_q.mstatus_mie;
      regs_d.mstatus_mpp  = regs_q.priv;
      regs_d.mepc         = trap_req_i.exc_pc;
      regs_d.mcause       = trap_req_i.cause;
      regs_d.mtval        = trap_req_i.tval;
    end else if (trap_req_i.restore_mret) begin
      regs_d.priv         = regs_q.mstatus_mpp;
      regs_d.mstatus_mie  = regs_q.mstatus_mpie;
      regs_d.mstatus_mpie = 1'b1;
      regs_d.mstatus_mpp  = PRIV_LVL_U;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      regs_q <= '{
        priv:         PRIV_LVL_M,
        mstatus_mie:  MSTATUS_RESET[MSTATUS_MIE_BIT],
        mstatus_mpie: MSTATUS_RESET[MSTATUS_MPIE_BIT],
        mstatus_mpp:  priv_lvl_e'(MSTATUS_RESET[MSTATUS_MPP_HI:MSTATUS_MPP_LO]),
        mstatus_tw:   MSTATUS_RESET[MSTATUS_TW_BIT],
        mscratch:     '0,
        mepc:         '0,
        mcause:       '0,
        mtval:        '0,
        mtvec:        32'(MTVEC_MODE_VECTORED)   // reads 1 out of reset
      };
    end else begin
      regs_q <= regs_d;
    end
  end

  assign trap_view_o       = regs_q;
  assign priv_mode_o       = regs_q.priv;
  assign csr_mstatus_mie_o = regs_q.mstatus_mie;
  assign csr_mstatus_tw_o  = regs_q.mstatus_tw;
  assign csr_mepc_o        = regs_q.mepc;
  assign csr_mtvec_o       = regs_q.mtvec;

endmodule
